/* afu_settings.svh */
`ifndef AFU_SETTINGS_SVH
`define AFU_SETTINGS_SVH

// ------------------------------
// bus widths
// ------------------------------
`define AFU_ADDR_W 58
`define AFU_LINE_W 512
`define AFU_READ_NUM_W 8
// each read is four cache lines
`define AFU_LINES_PER_READ_LOG2 2

// ------------------------------
// handshake line layout
// ------------------------------
`define AFU_FLAG0_BIT 480
`define AFU_FLAG1_BIT 482
`define AFU_SIZE_LSB 448
`define AFU_FENCE_BIT 511
`define AFU_STATUS_CODE 16

// lookup queue entries, power of two
`define AFU_LOOKUP_DEPTH 4

`endif

/* afu_pkg.sv */
`include "afu_settings.svh"

package afu_pkg;

	typedef logic [`AFU_ADDR_W-1:0] addr_t;
	typedef logic [`AFU_LINE_W-1:0] line_t;
	// engine lookup index, 16 entries per line
	typedef logic [31:0] word_t;
	// one bit wider than the read count
	typedef logic [`AFU_READ_NUM_W:0] batch_t;
	typedef logic [`AFU_READ_NUM_W+`AFU_LINES_PER_READ_LOG2:0] line_cnt_t;

	// batch controller states
	typedef enum logic [3:0] {
		st_idle,
		st_poll_req,
		st_poll_wait,
		st_load,
		st_run,
		st_output,
		st_fence_out,
		st_status_out,
		st_fence_final
	} ctrl_state_t;

endpackage

/* afu_rd_if.sv */
// one paired read request, k line and l line
interface afu_rd_if import afu_pkg::*; ();

	logic  req;
	addr_t addr_k;
	addr_t addr_l;
	logic  grant;

	modport requester (
		output req,
		output addr_k,
		output addr_l,
		input  grant
	);

	modport arbiter (
		input  req,
		input  addr_k,
		input  addr_l,
		output grant
	);

endinterface

/* batch_ctrl.sv */
`include "afu_settings.svh"

module batch_ctrl import afu_pkg::*; (
	input  logic  CLK_200M,
	input  logic  reset_n,
	input  logic  core_start,
	input  logic  stall_q,
	input  addr_t hand_ptr,
	input  addr_t input_base,
	input  addr_t output_base,
	input  logic  pair_valid,
	input  line_t pair_k,
	input  line_t pair_l,
	input  logic  eng_load_done,
	input  logic  eng_output_request,
	input  logic  eng_output_valid,
	input  line_t eng_output_data,
	input  logic  eng_output_finish,
	afu_rd_if.requester rd,
	output logic   run_active,
	output logic   idle,
	output batch_t eng_batch_size,
	output logic   eng_load_valid,
	output line_t  eng_load_data,
	output logic   eng_dram_get,
	output line_t  eng_cl_k,
	output line_t  eng_cl_l,
	output logic   eng_output_permit,
	output logic   tx_wr_valid,
	output logic   tx_fence_valid,
	output addr_t  tx_wr_addr,
	output line_t  tx_data
);

	localparam line_t FENCE_LINE = line_t'(1) << `AFU_FENCE_BIT;
	// status code sits in the top 32 bits
	localparam line_t STATUS_LINE = line_t'(`AFU_STATUS_CODE) << (`AFU_LINE_W - 32);

	ctrl_state_t state;
	logic        parity;
	line_cnt_t   load_ptr;
	line_cnt_t   line_cnt;
	addr_t       out_idx;
	logic        flag_set;

	assign line_cnt = line_cnt_t'(eng_batch_size) << `AFU_LINES_PER_READ_LOG2;
	assign flag_set = parity ? pair_l[`AFU_FLAG1_BIT] : pair_l[`AFU_FLAG0_BIT];

	assign run_active = (state == st_run);
	assign idle = (state == st_idle);

	// ------------------------------
	// read requests
	// ------------------------------
	// load reads ask for the same line twice, only k is forwarded
	always_comb begin
		rd.req = 1'b0;
		rd.addr_k = hand_ptr;
		rd.addr_l = hand_ptr;
		if (state == st_poll_req) begin
			rd.req = 1'b1;
		end else if (state == st_load && load_ptr < line_cnt) begin
			rd.req = 1'b1;
			rd.addr_k = input_base + addr_t'(load_ptr);
			rd.addr_l = input_base + addr_t'(load_ptr);
		end
	end

	// ------------------------------
	// batch state machine
	// ------------------------------
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			state <= st_idle;
			parity <= 1'b0;
			load_ptr <= '0;
			out_idx <= '0;
			eng_load_valid <= 1'b0;
			eng_dram_get <= 1'b0;
			eng_output_permit <= 1'b0;
			tx_wr_valid <= 1'b0;
			tx_fence_valid <= 1'b0;
		end else begin
			eng_load_valid <= (state == st_load) && pair_valid;
			eng_dram_get <= (state == st_run) && pair_valid;
			tx_wr_valid <= 1'b0;
			tx_fence_valid <= 1'b0;
			case (state)
				st_idle: begin
					// parity is kept across batches
					load_ptr <= '0;
					out_idx <= '0;
					eng_output_permit <= 1'b0;
					if (core_start)
						state <= st_poll_req;
				end
				st_poll_req: begin
					if (rd.grant)
						state <= st_poll_wait;
				end
				st_poll_wait: begin
					if (pair_valid) begin
						if (flag_set) begin
							parity <= ~parity;
							state <= st_load;
						end else begin
							state <= st_poll_req;
						end
					end
				end
				st_load: begin
					if (rd.grant)
						load_ptr <= load_ptr + 1'b1;
					if (eng_load_done)
						state <= st_run;
				end
				st_run: begin
					if (!stall_q && eng_output_request) begin
						eng_output_permit <= 1'b1;
						state <= st_output;
					end
				end
				st_output: begin
					// a line counts as accepted only outside stall
					if (!stall_q) begin
						if (eng_output_valid) begin
							tx_wr_valid <= 1'b1;
							out_idx <= out_idx + 1'b1;
						end
						if (eng_output_finish) begin
							eng_output_permit <= 1'b0;
							state <= st_fence_out;
						end
					end
				end
				st_fence_out: begin
					if (!stall_q) begin
						tx_fence_valid <= 1'b1;
						state <= st_status_out;
					end
				end
				st_status_out: begin
					if (!stall_q) begin
						tx_wr_valid <= 1'b1;
						state <= st_fence_final;
					end
				end
				st_fence_final: begin
					if (!stall_q) begin
						tx_fence_valid <= 1'b1;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// ------------------------------
	// payload registers
	// ------------------------------
	always_ff @(posedge CLK_200M) begin
		if (state == st_poll_wait && pair_valid && flag_set)
			eng_batch_size <= pair_l[`AFU_SIZE_LSB +: $bits(batch_t)];
		if (pair_valid) begin
			eng_load_data <= pair_k;
			eng_cl_k <= pair_k;
			eng_cl_l <= pair_l;
		end
		case (state)
			st_output: begin
				tx_wr_addr <= output_base + out_idx;
				tx_data <= eng_output_data;
			end
			st_status_out: begin
				tx_wr_addr <= hand_ptr;
				tx_data <= STATUS_LINE;
			end
			default: begin
				tx_wr_addr <= '0;
				tx_data <= FENCE_LINE;
			end
		endcase
	end

	// no data write on the bus while idle or waiting on the handshake
	assert property (@(posedge CLK_200M) disable iff (!reset_n)
		(state inside {st_idle, st_poll_wait}) |-> !tx_wr_valid);

endmodule

/* lookup_req.sv */
`include "afu_settings.svh"

module lookup_req import afu_pkg::*; (
	input  logic  CLK_200M,
	input  logic  reset_n,
	input  logic  stall_q,
	input  logic  run_active,
	input  addr_t bwt_base,
	input  logic  eng_lookup_valid,
	input  word_t eng_addr_k,
	input  word_t eng_addr_l,
	afu_rd_if.requester rd,
	output logic  eng_lookup_stall
);

	localparam int PTR_W = $clog2(`AFU_LOOKUP_DEPTH);

	addr_t q_k [`AFU_LOOKUP_DEPTH];
	addr_t q_l [`AFU_LOOKUP_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic push;
	logic pop;
	logic full;

	assign push = run_active && eng_lookup_valid;
	assign pop = rd.grant;
	assign full = (count == (PTR_W+1)'(`AFU_LOOKUP_DEPTH));

	// stop the engine with one entry to spare
	assign eng_lookup_stall = stall_q || (count >= (PTR_W+1)'(`AFU_LOOKUP_DEPTH - 1));

	// oldest entry goes to the arbiter
	assign rd.req = (count != '0);
	assign rd.addr_k = q_k[rd_ptr];
	assign rd.addr_l = q_l[rd_ptr];

	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// 16 index entries per cache line
	always_ff @(posedge CLK_200M) begin
		if (push) begin
			q_k[wr_ptr] <= bwt_base + addr_t'(eng_addr_k >> 4);
			q_l[wr_ptr] <= bwt_base + addr_t'(eng_addr_l >> 4);
		end
	end

	// engine must honour eng_lookup_stall
	assert property (@(posedge CLK_200M) disable iff (!reset_n)
		push |-> (!full || pop));

endmodule

/* rd_arbiter.sv */
module rd_arbiter import afu_pkg::*; (
	input  logic  CLK_200M,
	input  logic  reset_n,
	input  logic  stall_q,
	afu_rd_if.arbiter ctrl_rd,
	afu_rd_if.arbiter look_rd,
	output logic  tx_rd_valid,
	output addr_t tx_rd_addr
);

	logic  l_pending;
	addr_t l_hold;
	logic  can_grant;
	logic  any_grant;

	// ------------------------------
	// fixed priority, controller first
	// ------------------------------
	assign can_grant = !stall_q && !l_pending;
	assign ctrl_rd.grant = can_grant && ctrl_rd.req;
	assign look_rd.grant = can_grant && look_rd.req && !ctrl_rd.req;
	assign any_grant = ctrl_rd.grant || look_rd.grant;

	// k beat after the grant, l beat one cycle later
	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			tx_rd_valid <= 1'b0;
			l_pending <= 1'b0;
		end else begin
			tx_rd_valid <= any_grant || l_pending;
			l_pending <= any_grant;
		end
	end

	always_ff @(posedge CLK_200M) begin
		if (ctrl_rd.grant) begin
			tx_rd_addr <= ctrl_rd.addr_k;
			l_hold <= ctrl_rd.addr_l;
		end else if (look_rd.grant) begin
			tx_rd_addr <= look_rd.addr_k;
			l_hold <= look_rd.addr_l;
		end else if (l_pending) begin
			tx_rd_addr <= l_hold;
		end
	end

	assert property (@(posedge CLK_200M) disable iff (!reset_n)
		!(ctrl_rd.grant && look_rd.grant));

	// a waiting requester keeps its pair until the grant
	assert property (@(posedge CLK_200M) disable iff (!reset_n)
		(ctrl_rd.req && !ctrl_rd.grant) |=>
		(ctrl_rd.req && $stable(ctrl_rd.addr_k) && $stable(ctrl_rd.addr_l)));

	assert property (@(posedge CLK_200M) disable iff (!reset_n)
		(look_rd.req && !look_rd.grant) |=>
		(look_rd.req && $stable(look_rd.addr_k) && $stable(look_rd.addr_l)));

endmodule

/* rsp_pairer.sv */
module rsp_pairer import afu_pkg::*; (
	input  logic  CLK_200M,
	input  logic  reset_n,
	input  logic  clear,
	input  logic  rx_valid,
	input  line_t rx_data,
	output logic  pair_valid,
	output line_t pair_k,
	output line_t pair_l
);

	// high when the next beat is an l line
	logic  l_beat;
	line_t k_hold;

	always_ff @(posedge CLK_200M) begin
		if (!reset_n) begin
			l_beat <= 1'b0;
			pair_valid <= 1'b0;
		end else begin
			pair_valid <= rx_valid && l_beat;
			if (clear)
				l_beat <= 1'b0;
			else if (rx_valid)
				l_beat <= ~l_beat;
		end
	end

	// k waits here for its partner
	always_ff @(posedge CLK_200M) begin
		if (rx_valid && !l_beat)
			k_hold <= rx_data;
		if (rx_valid && l_beat) begin
			pair_k <= k_hold;
			pair_l <= rx_data;
		end
	end

endmodule

/* afu_core.sv */
module afu_core import afu_pkg::*; (
	input  logic   CLK_200M,
	input  logic   reset_n,
	input  logic   core_start,
	input  addr_t  hand_ptr,
	input  addr_t  input_base,
	input  addr_t  output_base,
	input  addr_t  bwt_base,
	// host read requests and responses
	input  logic   tx_rd_almostfull,
	output logic   tx_rd_valid,
	output addr_t  tx_rd_addr,
	input  logic   rx_valid,
	input  line_t  rx_data,
	// host writes
	input  logic   tx_wr_almostfull,
	output logic   tx_wr_valid,
	output logic   tx_fence_valid,
	output addr_t  tx_wr_addr,
	output line_t  tx_data,
	// search engine
	input  logic   eng_lookup_valid,
	input  word_t  eng_addr_k,
	input  word_t  eng_addr_l,
	input  logic   eng_load_done,
	input  logic   eng_output_request,
	input  logic   eng_output_valid,
	input  line_t  eng_output_data,
	input  logic   eng_output_finish,
	output logic   eng_lookup_stall,
	output logic   eng_load_valid,
	output line_t  eng_load_data,
	output batch_t eng_batch_size,
	output logic   eng_dram_get,
	output line_t  eng_cl_k,
	output line_t  eng_cl_l,
	output logic   eng_output_permit
);

	logic  stall_q;
	logic  run_active;
	logic  ctrl_idle;
	logic  pair_valid;
	line_t pair_k;
	line_t pair_l;

	afu_rd_if ctrl_link ();
	afu_rd_if look_link ();

	// one stall for the whole unit
	always_ff @(posedge CLK_200M) begin
		if (!reset_n)
			stall_q <= 1'b0;
		else
			stall_q <= tx_rd_almostfull || tx_wr_almostfull;
	end

	batch_ctrl u_batch_ctrl (
		.CLK_200M(CLK_200M), .reset_n(reset_n), .core_start(core_start), .stall_q(stall_q),
		.hand_ptr(hand_ptr), .input_base(input_base), .output_base(output_base),
		.pair_valid(pair_valid), .pair_k(pair_k), .pair_l(pair_l),
		.eng_load_done(eng_load_done), .eng_output_request(eng_output_request),
		.eng_output_valid(eng_output_valid), .eng_output_data(eng_output_data),
		.eng_output_finish(eng_output_finish), .rd(ctrl_link.requester),
		.run_active(run_active), .idle(ctrl_idle), .eng_batch_size(eng_batch_size),
		.eng_load_valid(eng_load_valid), .eng_load_data(eng_load_data),
		.eng_dram_get(eng_dram_get), .eng_cl_k(eng_cl_k), .eng_cl_l(eng_cl_l),
		.eng_output_permit(eng_output_permit), .tx_wr_valid(tx_wr_valid),
		.tx_fence_valid(tx_fence_valid), .tx_wr_addr(tx_wr_addr), .tx_data(tx_data)
	);

	lookup_req u_lookup_req (
		.CLK_200M(CLK_200M), .reset_n(reset_n), .stall_q(stall_q), .run_active(run_active),
		.bwt_base(bwt_base), .eng_lookup_valid(eng_lookup_valid),
		.eng_addr_k(eng_addr_k), .eng_addr_l(eng_addr_l), .rd(look_link.requester),
		.eng_lookup_stall(eng_lookup_stall)
	);

	rd_arbiter u_rd_arbiter (
		.CLK_200M(CLK_200M), .reset_n(reset_n), .stall_q(stall_q),
		.ctrl_rd(ctrl_link.arbiter), .look_rd(look_link.arbiter),
		.tx_rd_valid(tx_rd_valid), .tx_rd_addr(tx_rd_addr)
	);

	// responses come back in request order
	rsp_pairer u_rsp_pairer (
		.CLK_200M(CLK_200M), .reset_n(reset_n), .clear(ctrl_idle),
		.rx_valid(rx_valid), .rx_data(rx_data),
		.pair_valid(pair_valid), .pair_k(pair_k), .pair_l(pair_l)
	);

endmodule

/* tb_mem_model.sv */
`include "afu_settings.svh"

// in-order host memory with a handshake line and write counters
module tb_mem_model import afu_pkg::*; (
	input  logic        CLK_200M,
	input  logic        reset_n,
	input  logic [31:0] salt,
	input  addr_t       hand_ptr,
	input  line_t       hand_line,
	input  logic        tx_rd_valid,
	input  addr_t       tx_rd_addr,
	output logic        rx_valid,
	output line_t       rx_data,
	input  logic        tx_wr_valid,
	input  logic        tx_fence_valid,
	output int          wr_count,
	output int          fence_count
);

	localparam int RD_LAT = 3;

	// the output register is the last stage
	logic  pipe_valid [RD_LAT-1];
	addr_t pipe_addr [RD_LAT-1];

	// every address bit changes the line
	function automatic line_t line_at(input addr_t a);
		line_t l;
		if (a == hand_ptr)
			return hand_line;
		for (int w = 0; w < 16; w++)
			l[w*32 +: 32] = salt + a[31:0] * 32'h9e3779b1 + {6'b0, a[57:32]} * (w + 1) + w;
		return l;
	endfunction

	// ------------------------------
	// read responses, three cycles behind
	// ------------------------------
	always @(posedge CLK_200M) begin
		if (!reset_n) begin
			for (int i = 0; i < RD_LAT-1; i++)
				pipe_valid[i] <= 1'b0;
			rx_valid <= 1'b0;
		end else begin
			pipe_valid[0] <= tx_rd_valid;
			pipe_addr[0] <= tx_rd_addr;
			for (int i = 1; i < RD_LAT-1; i++) begin
				pipe_valid[i] <= pipe_valid[i-1];
				pipe_addr[i] <= pipe_addr[i-1];
			end
			rx_valid <= pipe_valid[RD_LAT-2];
			rx_data <= line_at(pipe_addr[RD_LAT-2]);
		end
	end

	// write log
	always @(posedge CLK_200M) begin
		if (!reset_n) begin
			wr_count <= 0;
			fence_count <= 0;
		end else begin
			if (tx_wr_valid)
				wr_count <= wr_count + 1;
			if (tx_fence_valid)
				fence_count <= fence_count + 1;
		end
	end

endmodule

/* tb_afu_core.sv */
`include "afu_settings.svh"

module tb_afu_core import afu_pkg::*; ();

	localparam int BATCH_A = 2;
	localparam int BATCH_B = 1;
	localparam int N_LOOK = 12;
	localparam int N_OUT = 5;
	localparam int RD_LINES = 1 << `AFU_LINES_PER_READ_LOG2;
	// load lines, two lines per lookup and the output lines of both batches
	localparam int TOTAL_LINES = (BATCH_A + BATCH_B) * RD_LINES + 2 * (2 * N_LOOK + N_OUT);
	localparam int LIMIT = TOTAL_LINES * 40 + 2000;

	logic   CLK_200M;
	logic   reset_n;
	logic   core_start;
	addr_t  hand_ptr;
	addr_t  input_base;
	addr_t  output_base;
	addr_t  bwt_base;
	logic   tx_rd_almostfull;
	logic   tx_rd_valid;
	addr_t  tx_rd_addr;
	logic   rx_valid;
	line_t  rx_data;
	logic   tx_wr_almostfull;
	logic   tx_wr_valid;
	logic   tx_fence_valid;
	addr_t  tx_wr_addr;
	line_t  tx_data;
	logic   eng_lookup_valid;
	word_t  eng_addr_k;
	word_t  eng_addr_l;
	logic   eng_load_done;
	logic   eng_output_request;
	logic   eng_output_valid;
	line_t  eng_output_data;
	logic   eng_output_finish;
	logic   eng_lookup_stall;
	logic   eng_load_valid;
	line_t  eng_load_data;
	batch_t eng_batch_size;
	logic   eng_dram_get;
	line_t  eng_cl_k;
	line_t  eng_cl_l;
	logic   eng_output_permit;

	logic [31:0] salt;
	line_t hand_line;
	line_t status_line;
	line_t fence_mask;
	int    wr_count;
	int    fence_count;
	logic  stall_ref;
	logic  stall_ref_d;
	logic  polling_ok;
	logic  rd_l_next;
	logic  coin;
	int    burst_left;
	int    val_errs;
	int    other_errs;
	int    cycles;
	int    load_seen;
	int    get_seen;
	int    fence_seen;
	int    poll_beats;
	int    wr_expected;
	addr_t exp_rd[$];
	addr_t exp_load[$];
	addr_t exp_cl_k[$];
	addr_t exp_cl_l[$];
	logic  exp_fence[$];
	addr_t exp_wr_addr[$];
	line_t exp_wr_data[$];

	afu_core u_dut (.*);

	tb_mem_model u_mem (.*);

	always #2 CLK_200M = ~CLK_200M;

	// ------------------------------
	// reference and helpers
	// ------------------------------
	function automatic addr_t ref_addr(input addr_t base, input word_t offset, input bit per_entry);
		// 16 index entries share a line
		if (per_entry)
			return base + addr_t'(offset / 16);
		return base + addr_t'(offset);
	endfunction

	function automatic line_t rand_line();
		line_t l;
		for (int w = 0; w < 16; w++)
			l[w*32 +: 32] = $urandom;
		return l;
	endfunction

	task automatic step();
		@(posedge CLK_200M);
		#1;
	endtask

	task automatic compare_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			val_errs++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compare_line(input string name, input line_t got, input line_t exp);
		if (got !== exp) begin
			val_errs++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compare_batch(input string name, input batch_t got, input batch_t exp);
		if (got !== exp) begin
			val_errs++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic compare_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			val_errs++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic expect_write(input logic fence, input addr_t a, input line_t d);
		exp_fence.push_back(fence);
		exp_wr_addr.push_back(a);
		exp_wr_data.push_back(d);
		if (!fence)
			wr_expected++;
	endtask

	task automatic finish_run();
		$display("errors: %0d wrong values, %0d other", val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	endtask

	// ------------------------------
	// one batch through the engine model
	// ------------------------------
	task automatic run_batch(input logic parity, input int size);
		line_t hs;
		line_t d;
		word_t k;
		word_t l;
		int    n_lines;
		int    i;
		n_lines = size * RD_LINES;
		load_seen = 0;
		get_seen = 0;
		fence_seen = 0;
		poll_beats = 0;
		// stale line, only the flag of the previous parity
		hs = '0;
		hs[`AFU_FLAG0_BIT] = parity;
		hand_line = hs;
		polling_ok = 1'b1;
		core_start = 1'b1;
		step();
		core_start = 1'b0;
		repeat (60) step();
		if (poll_beats == 0) begin
			other_errs++;
			$display("no poll reads seen at the handshake address");
		end
		for (i = 0; i < n_lines; i++) begin
			// load pairs read the same line twice
			exp_rd.push_back(ref_addr(input_base, i, 1'b0));
			exp_rd.push_back(ref_addr(input_base, i, 1'b0));
			exp_load.push_back(ref_addr(input_base, i, 1'b0));
		end
		hs[parity ? `AFU_FLAG1_BIT : `AFU_FLAG0_BIT] = 1'b1;
		hs[`AFU_SIZE_LSB +: $bits(batch_t)] = batch_t'(size);
		hand_line = hs;
		while (load_seen < n_lines)
			step();
		compare_batch("eng_batch_size", eng_batch_size, batch_t'(size));
		eng_load_done = 1'b1;
		step();
		eng_load_done = 1'b0;

		i = 0;
		while (i < N_LOOK) begin
			eng_lookup_valid = 1'b0;
			if (!eng_lookup_stall) begin
				k = $urandom;
				l = $urandom;
				eng_lookup_valid = 1'b1;
				eng_addr_k = k;
				eng_addr_l = l;
				exp_rd.push_back(ref_addr(bwt_base, k, 1'b1));
				exp_rd.push_back(ref_addr(bwt_base, l, 1'b1));
				exp_cl_k.push_back(ref_addr(bwt_base, k, 1'b1));
				exp_cl_l.push_back(ref_addr(bwt_base, l, 1'b1));
				i++;
			end
			step();
		end
		eng_lookup_valid = 1'b0;
		while (get_seen < N_LOOK)
			step();

		eng_output_request = 1'b1;
		while (!eng_output_permit)
			step();
		eng_output_request = 1'b0;
		d = rand_line();
		i = 0;
		while (i < N_OUT) begin
			eng_output_valid = 1'b1;
			eng_output_data = d;
			// taken at the next edge unless stalled
			if (!stall_ref) begin
				expect_write(1'b0, ref_addr(output_base, i, 1'b0), d);
				i++;
				d = rand_line();
			end
			step();
		end
		eng_output_valid = 1'b0;
		eng_output_finish = 1'b1;
		while (stall_ref)
			step();
		expect_write(1'b1, '0, fence_mask);
		expect_write(1'b0, hand_ptr, status_line);
		expect_write(1'b1, '0, fence_mask);
		step();
		eng_output_finish = 1'b0;
		while (fence_seen < 2)
			step();
		repeat (4) step();
	endtask

	// ------------------------------
	// stall model and almost-full bursts
	// ------------------------------
	always @(posedge CLK_200M) begin
		stall_ref <= reset_n ? (tx_rd_almostfull || tx_wr_almostfull) : 1'b0;
		stall_ref_d <= stall_ref;
	end

	always @(posedge CLK_200M) begin
		#1;
		if (burst_left > 0)
			burst_left--;
		else if ($urandom_range(0, 9) == 0)
			burst_left = $urandom_range(1, 6);
		coin = $urandom_range(0, 1);
		tx_rd_almostfull = (burst_left > 0) && coin;
		tx_wr_almostfull = (burst_left > 0) && !coin;
	end

	// ------------------------------
	// compare process
	// ------------------------------
	always @(posedge CLK_200M) begin
		if (reset_n) begin
			if (stall_ref_d && ((tx_rd_valid && !rd_l_next) || tx_wr_valid || tx_fence_valid)) begin
				other_errs++;
				$display("a read or write started while almost full was set");
			end
			if (stall_ref)
				compare_flag("eng_lookup_stall", eng_lookup_stall, 1'b1);
			if (tx_rd_valid) begin
				rd_l_next = !rd_l_next;
				if (polling_ok && tx_rd_addr == hand_ptr) begin
					poll_beats++;
				end else if (exp_rd.size() == 0) begin
					other_errs++;
					$display("read at %h that no test step asked for", tx_rd_addr);
				end else begin
					polling_ok = 1'b0;
					compare_addr("tx_rd_addr", tx_rd_addr, exp_rd.pop_front());
				end
			end
			if (tx_wr_valid || tx_fence_valid) begin
				if (exp_fence.size() == 0) begin
					other_errs++;
					$display("write to %h that no test step asked for", tx_wr_addr);
				end else if (exp_fence.pop_front()) begin
					void'(exp_wr_addr.pop_front());
					fence_seen++;
					if (!tx_fence_valid || tx_wr_valid) begin
						other_errs++;
						void'(exp_wr_data.pop_front());
						$display("a fence was due but a data write came out");
					end else begin
						compare_line("tx_data", tx_data & fence_mask, exp_wr_data.pop_front());
					end
				end else if (!tx_wr_valid) begin
					other_errs++;
					void'(exp_wr_addr.pop_front());
					void'(exp_wr_data.pop_front());
					$display("a data write was due but a fence came out");
				end else begin
					compare_addr("tx_wr_addr", tx_wr_addr, exp_wr_addr.pop_front());
					compare_line("tx_data", tx_data, exp_wr_data.pop_front());
				end
			end
			if (eng_load_valid) begin
				load_seen++;
				if (exp_load.size() == 0) begin
					other_errs++;
					$display("load pulse with no load line left");
				end else begin
					compare_line("eng_load_data", eng_load_data, u_mem.line_at(exp_load.pop_front()));
				end
			end
			if (eng_dram_get) begin
				get_seen++;
				if (exp_cl_k.size() == 0) begin
					other_errs++;
					$display("dram get pulse with no lookup pending");
				end else begin
					compare_line("eng_cl_k", eng_cl_k, u_mem.line_at(exp_cl_k.pop_front()));
					compare_line("eng_cl_l", eng_cl_l, u_mem.line_at(exp_cl_l.pop_front()));
				end
			end
		end
	end

	always @(posedge CLK_200M) begin
		cycles++;
		if (cycles >= LIMIT) begin
			other_errs++;
			$display("timeout after %0d cycles", cycles);
			finish_run();
		end
	end

	initial begin
		void'($urandom(32'h18fe));
		CLK_200M = 1'b0;
		reset_n = 1'b0;
		core_start = 1'b0;
		tx_rd_almostfull = 1'b0;
		tx_wr_almostfull = 1'b0;
		eng_lookup_valid = 1'b0;
		eng_addr_k = '0;
		eng_addr_l = '0;
		eng_load_done = 1'b0;
		eng_output_request = 1'b0;
		eng_output_valid = 1'b0;
		eng_output_data = '0;
		eng_output_finish = 1'b0;
		hand_ptr = 58'h100;
		input_base = 58'h1000;
		output_base = 58'h2000;
		bwt_base = 58'h10000;
		salt = $urandom;
		hand_line = '0;
		status_line = '0;
		status_line[`AFU_LINE_W-1 -: 32] = `AFU_STATUS_CODE;
		// only the marker bit of a fence line is defined
		fence_mask = '0;
		fence_mask[`AFU_FENCE_BIT] = 1'b1;
		stall_ref = 1'b0;
		stall_ref_d = 1'b0;
		polling_ok = 1'b0;
		rd_l_next = 1'b0;
		burst_left = 0;
		val_errs = 0;
		other_errs = 0;
		cycles = 0;
		wr_expected = 0;
		repeat (4) @(posedge CLK_200M);
		#1;
		reset_n = 1'b1;
		repeat (4) step();
		run_batch(1'b0, BATCH_A);
		// parity has flipped, flag 0 alone must not start a batch
		run_batch(1'b1, BATCH_B);
		repeat (10) step();
		if (exp_rd.size() != 0 || exp_load.size() != 0 || exp_cl_k.size() != 0) begin
			other_errs++;
			$display("expected reads or engine lines never arrived");
		end
		if (exp_fence.size() != 0 || wr_count != wr_expected || fence_count != 4) begin
			other_errs++;
			$display("write count %0d and fence count %0d do not match", wr_count, fence_count);
		end
		finish_run();
	end

endmodule

/* tb.f */
+incdir+.
afu_pkg.sv
afu_rd_if.sv
batch_ctrl.sv
lookup_req.sv
rd_arbiter.sv
rsp_pairer.sv
afu_core.sv
tb_mem_model.sv
tb_afu_core.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal
LINT      := --lint-only --timing
TOP       := tb_afu_core
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := Testbench failed
PASS_MSG  := Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

lint:
	$(VERILATOR) $(LINT) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
